// File: hw/uart_axil_regs.sv
`default_nettype none

module uart_axil_regs import uart_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  axil_req_t             req,
	output axil_rsp_t             rsp,
	input  rx_entry_t             head,
	input  logic                  empty,
	input  logic                  full,
	input  logic [FIFO_CNT_W-1:0] count,
	input  logic                  overrun_evt,
	input  logic                  push,
	output rx_cfg_t               cfg,
	output logic [15:0]           divisor,
	output logic                  pop,
	output logic                  fifo_clr
);

	logic        aw_rdy;   // drives awready and wready
	logic        ar_rdy;
	logic        bvalid;
	logic [1:0]  bresp;
	logic        rvalid;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        w_fire;   // write accepted this cycle
	logic        r_fire;   // read accepted this cycle
	logic [31:0] rd_mux;
	logic        rd_err;
	logic        wr_err;
	logic        ovr;      // sticky overrun
	logic        gerr;     // sticky global error
	logic        head_new; // a new entry reached head last cycle

	// ======================================================================
	// handshakes
	// ======================================================================
	assign w_fire = aw_rdy & req.awvalid & req.wvalid;
	assign r_fire = ar_rdy & req.arvalid;

	always_ff @(posedge clk) begin
		if (rst) begin
			aw_rdy <= 1'b0;
			ar_rdy <= 1'b0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			// one cycle ready pulse with no response pending
			aw_rdy <= ~aw_rdy & ~bvalid & req.awvalid & req.wvalid;
			ar_rdy <= ~ar_rdy & ~rvalid & req.arvalid;
			if (w_fire)
				bvalid <= 1'b1;
			else if (req.bready)
				bvalid <= 1'b0;
			if (r_fire)
				rvalid <= 1'b1;
			else if (req.rready)
				rvalid <= 1'b0;
		end
	end

	// response payload held until taken
	always_ff @(posedge clk) begin
		if (w_fire)
			bresp <= wr_err ? RESP_SLVERR : RESP_OKAY;
		if (r_fire) begin
			rdata <= rd_mux;
			rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
		end
	end

	assign rsp.awready = aw_rdy;
	assign rsp.wready  = aw_rdy;
	assign rsp.bresp   = bresp;
	assign rsp.bvalid  = bvalid;
	assign rsp.arready = ar_rdy;
	assign rsp.rdata   = rdata;
	assign rsp.rresp   = rresp;
	assign rsp.rvalid  = rvalid;

	// ======================================================================
	// decode
	// ======================================================================
	always_comb begin
		rd_err = 1'b0;
		case (req.araddr)
		ADDR_DATA:   rd_mux = empty ? 32'd0 : {1'b1, 20'd0, head};
		ADDR_STATUS: rd_mux = {23'd0, count, gerr, ovr, full, empty};
		ADDR_CTRL:   rd_mux = {25'd0, cfg}; // clear bit reads 0
		ADDR_BAUD:   rd_mux = {16'd0, divisor};
		default: begin
			rd_mux = 32'd0;
			rd_err = 1'b1;
		end
		endcase
	end

	assign wr_err = (req.awaddr != ADDR_DATA) && (req.awaddr != ADDR_STATUS) &&
		(req.awaddr != ADDR_CTRL) && (req.awaddr != ADDR_BAUD);

	assign pop      = r_fire & (req.araddr == ADDR_DATA) & ~empty;
	assign fifo_clr = w_fire & (req.awaddr == ADDR_CTRL) & req.wstrb[0] & req.wdata[7];

	// ======================================================================
	// registers
	// ======================================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			cfg      <= '0;
			divisor  <= 16'd0;
			ovr      <= 1'b0;
			gerr     <= 1'b0;
			head_new <= 1'b0;
		end else begin
			// entry moves to head on push into empty or on pop with more behind
			head_new <= ~fifo_clr & ((push & empty) | (pop & ((count > 5'd1) | push)));
			if (w_fire) begin
				case (req.awaddr)
				ADDR_STATUS: begin
					ovr  <= 1'b0;
					gerr <= 1'b0;
				end
				ADDR_CTRL: if (req.wstrb[0]) cfg <= rx_cfg_t'(req.wdata[6:0]);
				ADDR_BAUD: begin
					if (req.wstrb[0])
						divisor[7:0] <= req.wdata[7:0];
					if (req.wstrb[1])
						divisor[15:8] <= req.wdata[15:8];
				end
				default: ; // data writes dropped
				endcase
			end
			// set wins over a same cycle clear
			if (overrun_evt)
				ovr <= 1'b1;
			if (head_new && !empty && (head.brk || head.perr || head.ferr))
				gerr <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: hw/uart_baud_gen.sv
`default_nettype none

// 16x sample enable, one clock wide every divisor+1 clocks
module uart_baud_gen (
	input  logic        clk,
	input  logic        rst,
	input  logic [15:0] divisor,
	output logic        tick
);

	logic [15:0] cnt;   // down counter
	logic [15:0] div_q; // last divisor seen

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt   <= 16'd0;
			div_q <= 16'd0;
			tick  <= 1'b0;
		end else begin
			div_q <= divisor;
			if (divisor != div_q) begin
				// new rate starts from a full period
				cnt  <= divisor;
				tick <= 1'b0;
			end else if (cnt == 16'd0) begin
				cnt  <= divisor; // reload
				tick <= 1'b1;
			end else begin
				cnt  <= cnt - 16'd1;
				tick <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/uart_pkg.sv
`default_nettype none

package uart_pkg;

	// ======================================================================
	// fifo and sampler constants
	// ======================================================================
	localparam int FIFO_DEPTH = 16;            // receive fifo entries
	localparam int FIFO_CNT_W = 5;             // count must reach FIFO_DEPTH
	localparam logic [3:0] SAMPLE_TICK = 4'd7; // 16x tick at bit middle

	// register byte offsets
	localparam logic [3:0] ADDR_DATA   = 4'h0;
	localparam logic [3:0] ADDR_STATUS = 4'h4;
	localparam logic [3:0] ADDR_CTRL   = 4'h8;
	localparam logic [3:0] ADDR_BAUD   = 4'hC;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// ======================================================================
	// structures
	// ======================================================================
	typedef struct packed {
		logic       brk;   // break seen
		logic       perr;  // parity error
		logic       ferr;  // framing error
		logic [7:0] data;  // zero above word length
	} rx_entry_t;

	typedef struct packed {
		logic [2:0] parity_ctrl; // 001 odd 011 even
		logic [1:0] word_len;    // bits minus 5
		logic       two_stop;
		logic       enable;
	} rx_cfg_t;

	// master to slave
	typedef struct packed {
		logic [3:0]  awaddr;
		logic        awvalid;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic        wvalid;
		logic        bready;
		logic [3:0]  araddr;
		logic        arvalid;
		logic        rready;
	} axil_req_t;

	// slave to master
	typedef struct packed {
		logic        awready;
		logic        wready;
		logic [1:0]  bresp;
		logic        bvalid;
		logic        arready;
		logic [31:0] rdata;
		logic [1:0]  rresp;
		logic        rvalid;
	} axil_rsp_t;

endpackage

`default_nettype wire

// File: hw/uart_rx.sv
`default_nettype none

module uart_rx import uart_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      tick,
	input  logic      rxd,
	input  rx_cfg_t   cfg,
	input  logic      fifo_full,
	output logic      push,
	output rx_entry_t entry,
	output logic      overrun_evt
);

	logic [2:0]  sync;      // metastability chain
	logic [2:0]  smp;       // last three tick samples
	logic        vote;      // majority of smp
	logic        vote_q;    // vote one tick earlier
	logic        start_det; // voted line fell
	logic        busy;      // 0 idle  1 counting a frame
	logic [7:0]  cnt;       // tick count within frame
	logic [10:0] shreg;     // newest sample enters at bit 10

	logic [1:0]  stop_n;    // stop bits in frame
	logic        par_en;    // frame has a parity bit
	logic [3:0]  n_bits;    // start + data + parity + stop
	logic [7:0]  eof_cnt;   // half a bit before frame end
	logic [3:0]  lsb_idx;   // where data lsb sits in shreg
	logic [10:0] aligned;
	logic [7:0]  mask;
	logic [7:0]  data;
	logic        par_bit;
	logic        perr;
	logic        ferr;
	logic        eof_hit;

	// ======================================================================
	// input conditioning
	// ======================================================================
	always_ff @(posedge clk) begin
		if (rst)
			sync <= 3'b111; // idle line is high
		else
			sync <= {sync[1:0], rxd};
	end

	assign vote = (smp[0] & smp[1]) | (smp[0] & smp[2]) | (smp[1] & smp[2]);
	assign start_det = vote_q & ~vote;

	always_ff @(posedge clk) begin
		if (rst) begin
			smp    <= 3'b111;
			vote_q <= 1'b1;
		end else if (tick) begin
			smp    <= {smp[1:0], sync[2]};
			vote_q <= vote;
		end
	end

	// ======================================================================
	// frame timing
	// ======================================================================
	assign stop_n  = cfg.two_stop ? 2'd2 : 2'd1;
	assign par_en  = (cfg.parity_ctrl == 3'b001) || (cfg.parity_ctrl == 3'b011);
	assign n_bits  = 4'd6 + {2'd0, cfg.word_len} + {3'd0, par_en} + {2'd0, stop_n};
	assign eof_cnt = {n_bits, 4'd0} - 8'd8; // 16 ticks per bit
	assign eof_hit = tick & busy & (cnt == eof_cnt);

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			cnt  <= 8'd0;
		end else if (!cfg.enable) begin
			busy <= 1'b0; // receiver off
			cnt  <= 8'd0;
		end else if (tick) begin
			if (!busy) begin
				if (start_det) begin
					busy <= 1'b1;
					cnt  <= 8'd0;
				end
			end else begin
				cnt <= cnt + 8'd1;
				// start bit must still be low at its middle
				if (cnt == {4'd0, SAMPLE_TICK} && vote)
					busy <= 1'b0;
				if (cnt == eof_cnt)
					busy <= 1'b0; // back to idle in the stop bit
			end
		end
	end

	// sample at each bit middle
	always_ff @(posedge clk) begin
		if (tick && busy && cnt[3:0] == SAMPLE_TICK)
			shreg <= {vote, shreg[10:1]};
	end

	// ======================================================================
	// field extraction
	// ======================================================================
	// from the top down shreg holds stop bits, parity, data msb..lsb
	assign lsb_idx = 4'd6 - {2'd0, stop_n} - {3'd0, par_en} - {2'd0, cfg.word_len};
	assign aligned = shreg >> lsb_idx;
	assign mask    = 8'hff >> (2'd3 - cfg.word_len); // keep word_len+5 bits
	assign data    = aligned[7:0] & mask;
	assign par_bit = cfg.two_stop ? shreg[8] : shreg[9];

	always_comb begin
		case (cfg.parity_ctrl)
		3'b001:  perr = ~(^data ^ par_bit); // odd
		3'b011:  perr = ^data ^ par_bit;    // even
		default: perr = 1'b0;
		endcase
	end

	// every stop bit must be high
	assign ferr = ~shreg[10] | (cfg.two_stop & ~shreg[9]);

	assign entry.data = data;
	assign entry.perr = perr;
	assign entry.ferr = ferr;
	assign entry.brk  = (data == 8'd0) & ~shreg[10]; // line held low

	// end of frame goes to the fifo or counts as overrun
	assign push        = eof_hit & ~fifo_full;
	assign overrun_evt = eof_hit & fifo_full;

endmodule

`default_nettype wire

// File: hw/uart_rx_fifo.sv
`default_nettype none

module uart_rx_fifo import uart_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  clr,
	input  logic                  push,
	input  logic                  pop,
	input  rx_entry_t             din,
	output rx_entry_t             head,
	output logic                  empty,
	output logic                  full,
	output logic [FIFO_CNT_W-1:0] count
);

	rx_entry_t mem [FIFO_DEPTH];

	logic [FIFO_CNT_W-2:0] wr_ptr; // wraps at FIFO_DEPTH
	logic [FIFO_CNT_W-2:0] rd_ptr;
	logic                  do_push;
	logic                  do_pop;

	assign empty   = (count == '0);
	assign full    = (count == FIFO_CNT_W'(FIFO_DEPTH));
	assign do_push = push & ~full;  // drop on full
	assign do_pop  = pop & ~empty;  // nothing to pop
	assign head    = mem[rd_ptr];   // oldest entry, shows the cycle after its push

	// storage
	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	// pointers and occupancy
	always_ff @(posedge clk) begin
		if (rst || clr) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
			2'b10:   count <= count + 1'b1;
			2'b01:   count <= count - 1'b1;
			default: count <= count; // both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/uart_rx_top.sv
`default_nettype none

module uart_rx_top import uart_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      rxd,
	input  axil_req_t req,
	output axil_rsp_t rsp
);

	rx_cfg_t               cfg;
	logic [15:0]           divisor;
	logic                  tick;        // 16x enable
	logic                  push;
	rx_entry_t             entry;
	logic                  overrun_evt;
	logic                  pop;
	logic                  fifo_clr;
	rx_entry_t             head;
	logic                  empty;
	logic                  full;
	logic [FIFO_CNT_W-1:0] count;

	uart_axil_regs u_regs (
		.clk(clk), .rst(rst), .req(req), .rsp(rsp),
		.head(head), .empty(empty), .full(full), .count(count),
		.overrun_evt(overrun_evt), .push(push),
		.cfg(cfg), .divisor(divisor), .pop(pop), .fifo_clr(fifo_clr)
	);

	uart_baud_gen u_baud (
		.clk(clk), .rst(rst), .divisor(divisor), .tick(tick)
	);

	uart_rx u_rx (
		.clk(clk), .rst(rst), .tick(tick), .rxd(rxd), .cfg(cfg),
		.fifo_full(full), .push(push), .entry(entry), .overrun_evt(overrun_evt)
	);

	uart_rx_fifo u_fifo (
		.clk(clk), .rst(rst), .clr(fifo_clr), .push(push), .pop(pop),
		.din(entry), .head(head), .empty(empty), .full(full), .count(count)
	);

endmodule

`default_nettype wire

// File: list.f
hw/uart_pkg.sv
hw/uart_baud_gen.sv
hw/uart_rx_fifo.sv
hw/uart_rx.sv
hw/uart_axil_regs.sv
hw/uart_rx_top.sv
testbench/uart_rx_sva.sv
testbench/uart_rx_tb.sv

// File: run.sh
#!/bin/sh
# build and run, pass only if the pass line shows up
verilator --binary --timing --assert --top-module uart_rx_tb -f list.f -o uart_rx_sim \
	&& ./obj_dir/uart_rx_sim | grep "test passed" \
	|| { echo "simulation did not pass"; exit 1; }
exit 0

// File: testbench/uart_rx_sva.sv
`default_nettype none

// bus handshake and fifo occupancy rules, bound into the register block
module uart_rx_sva import uart_pkg::*; (
	input logic                  clk,
	input logic                  rst,
	input axil_req_t             req,
	input axil_rsp_t             rsp,
	input logic                  full,
	input logic [FIFO_CNT_W-1:0] count,
	input logic                  pop,
	input logic                  fifo_clr
);

	// ======================================================================
	// bus channels
	// ======================================================================
	a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
		rsp.bvalid && !req.bready |=> rsp.bvalid)
		else $error("bvalid dropped before bready");

	a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
		rsp.rvalid && !req.rready |=> rsp.rvalid && $stable(rsp.rdata))
		else $error("read response changed while stalled");

	// nothing valid or ready straight out of reset
	a_reset_quiet: assert property (@(posedge clk)
		rst |=> !rsp.bvalid && !rsp.rvalid && !rsp.awready && !rsp.arready)
		else $error("bus outputs active after reset");

	// ======================================================================
	// fifo
	// ======================================================================
	a_count_max: assert property (@(posedge clk) disable iff (rst)
		count <= FIFO_CNT_W'(FIFO_DEPTH))
		else $error("fifo count above depth");

	// frames arriving while full are dropped, only a pop or clear frees a slot
	a_full_hold: assert property (@(posedge clk) disable iff (rst)
		full && !pop && !fifo_clr |=> full)
		else $error("fifo left full without a pop or clear");

endmodule

// regs block sees the fifo full and count, and drives pop and clear
bind uart_axil_regs uart_rx_sva u_sva (.*);

`default_nettype wire

// File: testbench/uart_rx_tb.sv
`default_nettype none

module uart_rx_tb import uart_pkg::*;;

	localparam int DIV      = 3;               // tick every 4 clocks
	localparam int BIT_CLKS = 16 * (DIV + 1);  // clocks per serial bit
	localparam int TIMEOUT  = 40000;

	logic      clk;
	logic      rst;
	logic      rxd;
	axil_req_t req;
	axil_rsp_t rsp;
	int        cycles = 0;
	logic [31:0] lfsr;

	uart_rx_top uut (.clk(clk), .rst(rst), .rxd(rxd), .req(req), .rsp(rsp));

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT);
			$display("test failed");
			$fatal(1);
		end
	end

	// ======================================================================
	// helpers
	// ======================================================================
	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		$display("error %s: expected %h actual %h", name, exp, act);
		$display("test failed");
		$fatal(1);
	endtask

	// galois lfsr, one step per bit
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic rand_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr);
			b[i] = lfsr[0];
		end
	endtask

	// expected DATA word: valid, brk, perr, ferr, data
	function automatic logic [31:0] data_word(input logic [7:0] d, input logic perr,
			input logic ferr, input logic brk);
		return {1'b1, 20'd0, brk, perr, ferr, d};
	endfunction

	task automatic bit_wait(input int n);
		repeat (n * BIT_CLKS) @(posedge clk);
		#1;
	endtask

	// ======================================================================
	// bus tasks, entered and left 1 time unit after a rising edge
	// ======================================================================
	task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		logic seen;
		req.awaddr  = addr;
		req.wdata   = data;
		req.wstrb   = 4'hf;
		req.awvalid = 1'b1;
		req.wvalid  = 1'b1;
		do begin
			seen = rsp.awready & rsp.wready; // address and data taken together
			@(posedge clk);
			#1;
		end while (!seen);
		// both readies are one cycle pulses
		assert ({rsp.awready, rsp.wready} == 2'b00)
			else report_mismatch("write ready pulse", 32'h0,
				32'({rsp.awready, rsp.wready}));
		req.awvalid = 1'b0;
		req.wvalid  = 1'b0;
		while (!rsp.bvalid) begin
			@(posedge clk);
			#1;
		end
		resp = rsp.bresp; // bready high, taken at next edge
		@(posedge clk);
		#1;
	endtask

	task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		logic seen;
		req.araddr  = addr;
		req.arvalid = 1'b1;
		do begin
			seen = rsp.arready;
			@(posedge clk);
			#1;
		end while (!seen);
		req.arvalid = 1'b0;
		while (!rsp.rvalid) begin
			@(posedge clk);
			#1;
		end
		data = rsp.rdata;
		resp = rsp.rresp;
		@(posedge clk);
		#1;
	endtask

	// poll STATUS until the fifo holds n entries
	task automatic wait_count(input int n);
		logic [31:0] st;
		logic [1:0]  r;
		do axil_read(ADDR_STATUS, st, r);
		while (st[8:4] != n[4:0]);
	endtask

	// ======================================================================
	// serial line model
	// ======================================================================
	task automatic send_frame(input logic [7:0] val, input int nbits,
			input logic [2:0] par_ctrl, input logic flip_par, input logic stop_lvl,
			input logic two_stop);
		logic [7:0] m;
		logic       p;
		m = val & (8'hff >> (8 - nbits));
		rxd = 1'b0; // start
		bit_wait(1);
		for (int i = 0; i < nbits; i++) begin
			rxd = m[i]; // lsb first
			bit_wait(1);
		end
		if (par_ctrl == 3'b001 || par_ctrl == 3'b011) begin
			p = (par_ctrl == 3'b001) ? ~^m : ^m;
			rxd = p ^ flip_par;
			bit_wait(1);
		end
		rxd = stop_lvl;
		bit_wait(1);
		if (two_stop) begin
			rxd = stop_lvl;
			bit_wait(1);
		end
		rxd = 1'b1; // idle gap
		bit_wait(2);
	endtask

	// ======================================================================
	// tests
	// ======================================================================
	initial begin
		logic [7:0]  b;
		logic [7:0]  q [$];
		logic [31:0] d;
		logic [1:0]  r;
		lfsr   = 32'h35e11cc5;
		rxd    = 1'b1;
		req    = '0;
		req.bready = 1'b1;
		req.rready = 1'b1;
		rst    = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;

		axil_write(ADDR_BAUD, DIV, r);
		axil_write(ADDR_CTRL, 32'h0d, r); // 8N1 enabled
		axil_read(ADDR_BAUD, d, r);
		assert (d == DIV) else report_mismatch("baud readback", DIV, d);

		// 1. five bytes in 8N1
		for (int i = 0; i < 5; i++) begin
			rand_byte(b);
			q.push_back(b);
			send_frame(b, 8, 3'b000, 1'b0, 1'b1, 1'b0);
		end
		wait_count(5);
		for (int i = 0; i < 5; i++) begin
			axil_read(ADDR_DATA, d, r);
			assert (d == data_word(q[i], 0, 0, 0))
				else report_mismatch("8n1 data", data_word(q[i], 0, 0, 0), d);
		end
		q.delete();
		axil_read(ADDR_STATUS, d, r);
		assert (d == 32'h1) else report_mismatch("8n1 status", 32'h1, d);

		// 2. parity, 7E1 then 5O2, good then flipped
		axil_write(ADDR_CTRL, 32'h39, r);
		for (int k = 0; k < 2; k++) begin
			rand_byte(b);
			send_frame(b, 7, 3'b011, k[0], 1'b1, 1'b0);
			wait_count(1);
			axil_read(ADDR_DATA, d, r);
			assert (d == data_word(b & 8'h7f, k[0], 0, 0))
				else report_mismatch("7e1 parity", data_word(b & 8'h7f, k[0], 0, 0), d);
		end
		axil_write(ADDR_CTRL, 32'h13, r);
		for (int k = 0; k < 2; k++) begin
			rand_byte(b);
			send_frame(b, 5, 3'b001, k[0], 1'b1, 1'b1);
			wait_count(1);
			axil_read(ADDR_DATA, d, r);
			assert (d == data_word(b & 8'h1f, k[0], 0, 0))
				else report_mismatch("5o2 parity", data_word(b & 8'h1f, k[0], 0, 0), d);
		end
		axil_write(ADDR_STATUS, 32'h0, r); // drop sticky bits from the parity errors

		// 3. framing error and break
		axil_write(ADDR_CTRL, 32'h0d, r);
		send_frame(8'h5a, 8, 3'b000, 1'b0, 1'b0, 1'b0);
		send_frame(8'h00, 8, 3'b000, 1'b0, 1'b0, 1'b0);
		wait_count(2);
		axil_read(ADDR_DATA, d, r);
		assert (d == data_word(8'h5a, 0, 1, 0))
			else report_mismatch("framing", data_word(8'h5a, 0, 1, 0), d);
		axil_read(ADDR_DATA, d, r);
		assert (d == data_word(8'h00, 0, 1, 1))
			else report_mismatch("break", data_word(8'h00, 0, 1, 1), d);
		axil_read(ADDR_STATUS, d, r);
		assert (d[3] == 1'b1) else report_mismatch("global error set", 32'd1, 32'(d[3]));
		axil_write(ADDR_STATUS, 32'h0, r);
		axil_read(ADDR_STATUS, d, r);
		assert (d == 32'h1) else report_mismatch("global error clear", 32'h1, d);

		// 4. overrun, seventeen frames unread
		for (int i = 0; i < 17; i++) begin
			rand_byte(b);
			q.push_back(b);
			send_frame(b, 8, 3'b000, 1'b0, 1'b1, 1'b0);
		end
		axil_read(ADDR_STATUS, d, r);
		assert (d == 32'h106) else report_mismatch("overrun status", 32'h106, d);
		for (int i = 0; i < 16; i++) begin
			axil_read(ADDR_DATA, d, r);
			assert (d == data_word(q[i], 0, 0, 0))
				else report_mismatch("drain", data_word(q[i], 0, 0, 0), d);
		end
		axil_read(ADDR_DATA, d, r); // seventeenth is gone
		assert (d == 32'h0) else report_mismatch("lost byte", 32'h0, d);
		axil_read(ADDR_STATUS, d, r);
		assert (d == 32'h5) else report_mismatch("drained status", 32'h5, d);

		// 5. corner cases
		rxd = 1'b0; // glitch of a quarter bit
		repeat (BIT_CLKS / 4) @(posedge clk);
		#1;
		rxd = 1'b1;
		bit_wait(12);
		axil_read(ADDR_DATA, d, r);
		assert (d == 32'h0) else report_mismatch("glitch ignored", 32'h0, d);
		axil_read(4'h2, d, r);
		assert (r == RESP_SLVERR)
			else report_mismatch("unmapped read", 32'(RESP_SLVERR), 32'(r));
		assert (d == 32'h0) else report_mismatch("unmapped data", 32'h0, d);
		axil_write(4'h6, 32'h1, r);
		assert (r == RESP_SLVERR)
			else report_mismatch("unmapped write", 32'(RESP_SLVERR), 32'(r));
		send_frame(8'h11, 8, 3'b000, 1'b0, 1'b1, 1'b0);
		send_frame(8'h22, 8, 3'b000, 1'b0, 1'b1, 1'b0);
		wait_count(2);
		axil_write(ADDR_CTRL, 32'h8d, r); // clear fifo, keep 8N1
		axil_read(ADDR_STATUS, d, r);
		assert (d[8:0] == 9'h5) else report_mismatch("fifo clear", 32'h5, d);
		axil_read(ADDR_CTRL, d, r);
		assert (d == 32'h0d) else report_mismatch("ctrl readback", 32'h0d, d);

		// back-pressure, a stalled response holds only its own channel
		req.bready = 1'b0;
		axil_write(ADDR_BAUD, DIV, r);
		axil_read(ADDR_BAUD, d, r);
		assert (d == DIV) else report_mismatch("read past write stall", DIV, d);
		req.bready = 1'b1;
		@(posedge clk);
		#1;
		req.rready = 1'b0;
		axil_read(ADDR_CTRL, d, r);
		axil_write(ADDR_STATUS, 32'h0, r); // clears overrun while the read waits
		repeat (4) @(posedge clk);
		#1;
		req.rready = 1'b1;
		@(posedge clk);
		#1;
		assert (d == 32'h0d) else report_mismatch("stalled read", 32'h0d, d);
		axil_read(ADDR_STATUS, d, r);
		assert (d == 32'h1) else report_mismatch("write past read stall", 32'h1, d);

		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire
